//--- filelist.f
common/lc3b_pkg.sv
mem_datapath/mem_port_regs.sv
mem_datapath/writeback_select.sv
mem_datapath/cond_branch_unit.sv
mem_datapath/mem_datapath.sv
verification/mem_datapath_assert.sv
verification/mem_datapath_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mem_datapath testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module mem_datapath_tb \
    -f filelist.f \
    -Mdir obj_dir -o mem_datapath_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/mem_datapath_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^TESTBENCH PASSED$'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- verification/mem_datapath_tb.sv
`timescale 1ns/1ps

module mem_datapath_tb;

    import lc3b_pkg::*;

    logic             clk;
    logic             rst_n;
    lc3b_control_word ctrl;
    lc3b_word         alu_out;
    lc3b_word         pc_out;
    lc3b_word         br_add_out;
    lc3b_word         sr1_out;
    lc3b_instr_u      instruction;
    lc3b_word         rdata;
    logic             read;
    logic             write;
    logic [1:0]       wmask;
    lc3b_word         address;
    lc3b_word         wdata;
    lc3b_word         regfile_data;
    logic             br_en;

    logic [15:0] lfsr_state = 16'd42621;
    lc3b_word    mar_model;
    lc3b_word    mdr_model;
    lc3b_nzp     cc_model;
    int          check_count;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    bit          timed_out;

    mem_datapath u_dut (.*);

    bind mem_datapath mem_datapath_assert u_assert (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // random source and reference model
    // ----------------------------------------------------------------------
    // taps 16, 14, 13 and 11 give a maximal length sequence.
    function automatic logic [15:0] random_bits(input int width);
        logic [15:0] value;
        logic        fb;
        int          i;
        value = '0;
        for (i = 0; i < width; i++)
        begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value      = {value[14:0], fb};
        end
        return value;
    endfunction

    function automatic lc3b_nzp expected_cc(input lc3b_word value);
        if (value[15])
            return 3'b100;
        if (value == 16'h0000)
            return 3'b010;
        return 3'b001;
    endfunction

    // one bit position per pass, so the sign fill is explicit.
    function automatic lc3b_word expected_shift(input lc3b_word src, input logic [3:0] amount,
                                                input logic arith, input logic right);
        lc3b_word value;
        int       i;
        value = src;
        for (i = 0; i < int'(amount); i++)
        begin
            if (!right)
                value = {value[14:0], 1'b0};
            else if (!arith)
                value = {1'b0, value[15:1]};
            else
                value = {value[15], value[15:1]};
        end
        return value;
    endfunction

    function automatic lc3b_word expected_regfile();
        logic [15:0] ins;
        ins = instruction;
        case (ctrl.regfilemux_sel)
            RF_ALU:   return alu_out;
            RF_MDR:   return mdr_model;
            RF_BRADD: return br_add_out;
            RF_PC:    return pc_out;
            RF_ZEXT8: return {8'h00, mdr_model[7:0]};
            RF_SHIFT: return expected_shift(sr1_out, ins[3:0], ins[5], ins[4]);
            RF_LDB:   return mar_model[0] ? {8'h00, mdr_model[15:8]} : {8'h00, mdr_model[7:0]};
            default:  return '0;
        endcase
    endfunction

    function automatic lc3b_word expected_mar_source();
        logic [15:0] ins;
        ins = instruction;
        case (ctrl.marmux_sel)
            MAR_ALU:   return alu_out;
            MAR_PC:    return pc_out;
            MAR_BRADD: return br_add_out;
            MAR_MDATA: return rdata;
            MAR_TRAP:  return 16'(ins[7:0]) << 1;   // trap table entries are words.
            default:   return '0;
        endcase
    endfunction

    function automatic lc3b_word expected_mdr_source();
        case (ctrl.mdrmux_sel)
            MDR_ALU:    return alu_out;
            MDR_MDATA:  return rdata;
            MDR_SR1_HI: return sr1_out << 8;
            default:    return '0;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // drive, step and check
    // ----------------------------------------------------------------------
    task automatic report_error(input string tag, input string msg);
        $display("[ERROR] %0t %s: %s", $time, tag, msg);
        error_count++;
    endtask

    task automatic check_outputs(input string tag);
        lc3b_word    exp_rf;
        logic        exp_br;
        logic [15:0] ins;
        ins         = instruction;
        exp_rf      = expected_regfile();
        // n, z and p each enable the branch on their own.
        exp_br      = (cc_model[2] & ins[11]) | (cc_model[1] & ins[10])
                      | (cc_model[0] & ins[9]);
        check_count += 5;
        assert (read === ctrl.mem_read && write === ctrl.mem_write
                && wmask === ctrl.mem_byte_enable)
        else report_error(tag, "strobes do not mirror ctrl");
        assert (address === mar_model)
        else report_error(tag, $sformatf("address %h, expected %h", address, mar_model));
        assert (wdata === mdr_model)
        else report_error(tag, $sformatf("wdata %h, expected %h", wdata, mdr_model));
        assert (regfile_data === exp_rf)
        else report_error(tag, $sformatf("regfile_data %h, expected %h", regfile_data, exp_rf));
        assert (br_en === exp_br)
        else report_error(tag, $sformatf("br_en %b, expected %b", br_en, exp_br));
    endtask

    task automatic randomize_inputs();
        ctrl.load_mar        = 1'(random_bits(1));
        ctrl.load_mdr        = 1'(random_bits(1));
        ctrl.load_cc         = 1'(random_bits(1));
        ctrl.mem_read        = 1'(random_bits(1));
        ctrl.mem_write       = 1'(random_bits(1));
        ctrl.mem_byte_enable = 2'(random_bits(2));
        ctrl.marmux_sel      = marmux_sel_e'(3'(random_bits(3) % 16'd5));
        ctrl.mdrmux_sel      = mdrmux_sel_e'(2'(random_bits(2) % 16'd3));
        ctrl.regfilemux_sel  = regfilemux_sel_e'(3'(random_bits(3) % 16'd7));
        alu_out              = random_bits(16);
        pc_out               = random_bits(16);
        br_add_out           = random_bits(16);
        sr1_out              = random_bits(16);
        rdata                = random_bits(16);
        instruction          = lc3b_instr_u'(random_bits(16));
    endtask

    // registers see the inputs at the next rising edge. outputs are checked one half cycle later.
    task automatic step_cycle(input string tag);
        lc3b_word next_mar;
        lc3b_word next_mdr;
        lc3b_nzp  next_cc;
        next_mar = ctrl.load_mar ? expected_mar_source() : mar_model;
        next_mdr = ctrl.load_mdr ? expected_mdr_source() : mdr_model;
        next_cc  = ctrl.load_cc ? expected_cc(expected_regfile()) : cc_model;
        @(posedge clk);
        @(negedge clk);
        mar_model = next_mar;
        mdr_model = next_mdr;
        cc_model  = next_cc;
        check_outputs(tag);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int errors;
        errors = error_count - errors_before;
        $display("test %s done, %0d errors", name, errors);
        if (errors == 0)
            tests_passed++;
        else
            tests_failed++;
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic test_reset_strobes();
        int start;
        start = error_count;
        check_outputs("reset_strobes");
        repeat (20)
        begin
            randomize_inputs();
            ctrl.load_mar = 1'b0;
            ctrl.load_mdr = 1'b0;
            ctrl.load_cc  = 1'b0;
            step_cycle("reset_strobes");
        end
        finish_test("reset_strobes", start);
    endtask

    task automatic test_random_loads(input string name, input int cycles);
        int start;
        start = error_count;
        repeat (cycles)
        begin
            randomize_inputs();
            step_cycle(name);
        end
        finish_test(name, start);
    endtask

    task automatic test_writeback();
        int start;
        int kind;
        int amt;
        int parity;
        start = error_count;
        repeat (100)
        begin
            randomize_inputs();
            step_cycle("writeback");
        end
        for (kind = 0; kind < 3; kind++)
        begin
            for (amt = 0; amt < 16; amt++)
            begin
                randomize_inputs();
                ctrl.regfilemux_sel   = RF_SHIFT;
                instruction.shf.d    = (kind != 0);
                instruction.shf.a    = (kind == 2);
                instruction.shf.imm4 = 4'(amt);
                step_cycle("writeback");
            end
        end
        for (parity = 0; parity < 2; parity++)
        begin
            randomize_inputs();
            ctrl.load_mar   = 1'b1;
            ctrl.marmux_sel = MAR_ALU;
            alu_out[0]      = 1'(parity);
            ctrl.load_mdr   = 1'b1;
            ctrl.mdrmux_sel = MDR_MDATA;
            step_cycle("writeback");
            randomize_inputs();
            ctrl.load_mar       = 1'b0;
            ctrl.load_mdr       = 1'b0;
            ctrl.regfilemux_sel = RF_LDB;
            step_cycle("writeback");
        end
        finish_test("writeback", start);
    endtask

    task automatic test_cond_branch();
        int start;
        int v;
        int k;
        start = error_count;
        for (v = 0; v < 3; v++)
        begin
            randomize_inputs();
            ctrl.regfilemux_sel = RF_ALU;
            ctrl.load_cc        = 1'b1;
            if (v == 0)
                alu_out = random_bits(16) | 16'h8000;
            else if (v == 1)
                alu_out = 16'h0000;
            else
                alu_out = (random_bits(15) & 16'h7fff) | 16'h0001;
            step_cycle("cond_branch");
            for (k = 0; k < 8; k++)
            begin
                randomize_inputs();
                ctrl.load_cc        = 1'b0;       // cc must hold over this sweep.
                instruction.br.nzp = 3'(k);
                step_cycle("cond_branch");
            end
        end
        finish_test("cond_branch", start);
    endtask

    initial
    begin
        int waited;
        rst_n        = 1'b1;
        ctrl         = '0;
        alu_out      = '0;
        pc_out       = '0;
        br_add_out   = '0;
        sr1_out      = '0;
        rdata        = '0;
        instruction  = '0;
        instruction.br.nzp = 3'b111;   // every flag requested, so br_en shows the cc reset.
        mar_model    = '0;
        mdr_model    = '0;
        cc_model     = '0;
        check_count  = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n  = 1'b1;
        waited = 0;
        while (address !== 16'h0000 && waited < 16)
        begin
            @(negedge clk);
            waited++;
        end
        if (address !== 16'h0000)
        begin
            $display("timeout: address did not read zero after reset");
            timed_out = 1'b1;
        end
        else
        begin
            test_reset_strobes();
            test_random_loads("address_loading", 80);
            test_random_loads("data_loading", 80);
            test_writeback();
            test_cond_branch();
        end
        $display("tests passed %0d, tests failed %0d, errors %0d in %0d checks",
                 tests_passed, tests_failed, error_count, check_count);
        if (timed_out || error_count != 0)
            $display("TESTBENCH FAILED");
        else
            $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : mem_datapath_tb

//--- verification/mem_datapath_assert.sv
`timescale 1ns/1ps

module mem_datapath_assert (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lc3b_pkg::lc3b_control_word ctrl,
    input  logic                       read,
    input  logic                       write,
    input  logic [1:0]                 wmask,
    input  lc3b_pkg::lc3b_word         address,
    input  logic                       br_en
);

    // ----------------------------------------------------------------------
    // memory port
    // ----------------------------------------------------------------------
    strobe_mirror: assert property (@(posedge clk) disable iff (!rst_n)
        read == ctrl.mem_read && write == ctrl.mem_write && wmask == ctrl.mem_byte_enable)
    else $error("memory strobes differ from the control word");

    // the mar only moves on a load.
    mar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !ctrl.load_mar |=> $stable(address))
    else $error("address changed across an edge with load_mar low");

    // ----------------------------------------------------------------------
    // branch enable
    // ----------------------------------------------------------------------
    br_en_reset: assert property (@(posedge clk) !rst_n |-> !br_en)
    else $error("br_en is high while reset is asserted");

endmodule : mem_datapath_assert

//--- mem_datapath/mem_datapath.sv
`timescale 1ns/1ps

module mem_datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lc3b_pkg::lc3b_control_word ctrl,
    input  lc3b_pkg::lc3b_word         alu_out,
    input  lc3b_pkg::lc3b_word         pc_out,
    input  lc3b_pkg::lc3b_word         br_add_out,
    input  lc3b_pkg::lc3b_word         sr1_out,
    input  lc3b_pkg::lc3b_instr_u      instruction,
    input  lc3b_pkg::lc3b_word         rdata,
    output logic                       read,
    output logic                       write,
    output logic [1:0]                 wmask,
    output lc3b_pkg::lc3b_word         address,
    output lc3b_pkg::lc3b_word         wdata,
    output lc3b_pkg::lc3b_word         regfile_data,
    output logic                       br_en
);

    // ----------------------------------------------------------------------
    // memory facing registers
    // ----------------------------------------------------------------------
    mem_port_regs u_mem_port_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .alu_out     (alu_out),
        .pc_out      (pc_out),
        .br_add_out  (br_add_out),
        .sr1_out     (sr1_out),
        .rdata       (rdata),
        .instruction (instruction),
        .read        (read),
        .write       (write),
        .wmask       (wmask),
        .address     (address),
        .mdr_value   (wdata)           // the mdr is also the store data.
    );

    // ----------------------------------------------------------------------
    // write-back and condition codes
    // ----------------------------------------------------------------------
    writeback_select u_writeback_select (
        .ctrl_sel     (ctrl.regfilemux_sel),
        .alu_out      (alu_out),
        .pc_out       (pc_out),
        .br_add_out   (br_add_out),
        .sr1_out      (sr1_out),
        .mdr_value    (wdata),
        .address      (address),
        .instruction  (instruction),
        .regfile_data (regfile_data)
    );

    cond_branch_unit u_cond_branch_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_cc      (ctrl.load_cc),
        .regfile_data (regfile_data),
        .instruction  (instruction),
        .br_en        (br_en)
    );

endmodule : mem_datapath

//--- mem_datapath/cond_branch_unit.sv
`timescale 1ns/1ps

module cond_branch_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_cc,
    input  lc3b_pkg::lc3b_word    regfile_data,
    input  lc3b_pkg::lc3b_instr_u instruction,
    output logic                  br_en
);

    import lc3b_pkg::*;

    lc3b_nzp gencc_out;
    lc3b_nzp cc;

    // exactly one flag is set for any word.
    always_comb
    begin
        if (regfile_data[15])
            gencc_out = 3'b100;
        else if (regfile_data == '0)
            gencc_out = 3'b010;
        else
            gencc_out = 3'b001;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cc <= '0;
        else if (load_cc)
            cc <= gencc_out;
    end

    // ----------------------------------------------------------------------
    // branch enable
    // ----------------------------------------------------------------------
    assign br_en = |(cc & instruction.br.nzp);   // any flag requested by the branch.

endmodule : cond_branch_unit

//--- mem_datapath/writeback_select.sv
`timescale 1ns/1ps

module writeback_select (
    input  lc3b_pkg::regfilemux_sel_e ctrl_sel,
    input  lc3b_pkg::lc3b_word        alu_out,
    input  lc3b_pkg::lc3b_word        pc_out,
    input  lc3b_pkg::lc3b_word        br_add_out,
    input  lc3b_pkg::lc3b_word        sr1_out,
    input  lc3b_pkg::lc3b_word        mdr_value,
    input  lc3b_pkg::lc3b_word        address,
    input  lc3b_pkg::lc3b_instr_u     instruction,
    output lc3b_pkg::lc3b_word        regfile_data
);

    import lc3b_pkg::*;

    lc3b_word shift_out;
    lc3b_word zext8_out;
    lc3b_word ldb_out;
    lc3b_byte ldb_byte;
    logic     shift_a;
    logic     shift_d;
    logic [3:0] shift_amt;

    // ----------------------------------------------------------------------
    // shifter
    // ----------------------------------------------------------------------
    assign shift_a   = instruction.shf.a;
    assign shift_d   = instruction.shf.d;
    assign shift_amt = instruction.shf.imm4;

    always_comb
    begin
        if (!shift_d)
            shift_out = sr1_out << shift_amt;
        else if (!shift_a)
            shift_out = sr1_out >> shift_amt;
        else
            shift_out = lc3b_word'($signed(sr1_out) >>> shift_amt);   // keeps the sign bit.
    end

    // ----------------------------------------------------------------------
    // byte paths
    // ----------------------------------------------------------------------
    // the mar parity picks which half of the loaded word holds the byte.
    assign ldb_byte  = address[0] ? mdr_value[15:8] : mdr_value[7:0];
    assign ldb_out   = {8'h00, ldb_byte};
    assign zext8_out = {8'h00, mdr_value[7:0]};

    // ----------------------------------------------------------------------
    // register file source
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (ctrl_sel)
            RF_ALU:   regfile_data = alu_out;
            RF_MDR:   regfile_data = mdr_value;
            RF_BRADD: regfile_data = br_add_out;
            RF_PC:    regfile_data = pc_out;
            RF_ZEXT8: regfile_data = zext8_out;
            RF_SHIFT: regfile_data = shift_out;
            RF_LDB:   regfile_data = ldb_out;
            default:  regfile_data = '0;          // code 7 is not used.
        endcase
    end

endmodule : writeback_select

//--- mem_datapath/mem_port_regs.sv
`timescale 1ns/1ps

module mem_port_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lc3b_pkg::lc3b_control_word ctrl,
    input  lc3b_pkg::lc3b_word         alu_out,
    input  lc3b_pkg::lc3b_word         pc_out,
    input  lc3b_pkg::lc3b_word         br_add_out,
    input  lc3b_pkg::lc3b_word         sr1_out,
    input  lc3b_pkg::lc3b_word         rdata,
    input  lc3b_pkg::lc3b_instr_u      instruction,
    output logic                       read,
    output logic                       write,
    output logic [1:0]                 wmask,
    output lc3b_pkg::lc3b_word         address,
    output lc3b_pkg::lc3b_word         mdr_value
);

    import lc3b_pkg::*;

    lc3b_word trap_addr;
    lc3b_word marmux_out;
    lc3b_word mdrmux_out;

    // the strobes come straight from the control word.
    assign read  = ctrl.mem_read;
    assign write = ctrl.mem_write;
    assign wmask = ctrl.mem_byte_enable;

    // ----------------------------------------------------------------------
    // address side
    // ----------------------------------------------------------------------
    assign trap_addr = {7'b0, instruction.br.offset9[7:0], 1'b0};   // word index to byte address.

    always_comb
    begin
        case (ctrl.marmux_sel)
            MAR_ALU:   marmux_out = alu_out;
            MAR_PC:    marmux_out = pc_out;
            MAR_BRADD: marmux_out = br_add_out;
            MAR_MDATA: marmux_out = rdata;
            MAR_TRAP:  marmux_out = trap_addr;
            default:   marmux_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            address <= '0;
        else if (ctrl.load_mar)
            address <= marmux_out;
    end

    // ----------------------------------------------------------------------
    // data side
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (ctrl.mdrmux_sel)
            MDR_ALU:    mdrmux_out = alu_out;
            MDR_MDATA:  mdrmux_out = rdata;
            MDR_SR1_HI: mdrmux_out = {sr1_out[7:0], 8'h00};   // odd byte lane of a stb.
            default:    mdrmux_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mdr_value <= '0;
        else if (ctrl.load_mdr)
            mdr_value <= mdrmux_out;
    end

endmodule : mem_port_regs

//--- common/lc3b_pkg.sv
package lc3b_pkg;

    // ----------------------------------------------------------------------
    // basic datapath types
    // ----------------------------------------------------------------------
    typedef logic [15:0] lc3b_word;
    typedef logic [7:0]  lc3b_byte;
    typedef logic [2:0]  lc3b_nzp;       // n, z, p from msb to lsb.

    // ----------------------------------------------------------------------
    // multiplexer selectors
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        MAR_ALU   = 3'd0,
        MAR_PC    = 3'd1,
        MAR_BRADD = 3'd2,
        MAR_MDATA = 3'd3,                // memory read data for indirect loads.
        MAR_TRAP  = 3'd4
    } marmux_sel_e;

    typedef enum logic [1:0] {
        MDR_ALU    = 2'd0,
        MDR_MDATA  = 2'd1,
        MDR_SR1_HI = 2'd2                // sr1 in the high byte for odd-byte stores.
    } mdrmux_sel_e;

    typedef enum logic [2:0] {
        RF_ALU   = 3'd0,
        RF_MDR   = 3'd1,
        RF_BRADD = 3'd2,
        RF_PC    = 3'd3,
        RF_ZEXT8 = 3'd4,
        RF_SHIFT = 3'd5,
        RF_LDB   = 3'd6
    } regfilemux_sel_e;

    typedef struct packed {
        logic            load_mar;
        logic            load_mdr;
        logic            load_cc;
        logic            mem_read;
        logic            mem_write;
        logic [1:0]      mem_byte_enable;
        marmux_sel_e     marmux_sel;
        mdrmux_sel_e     mdrmux_sel;
        regfilemux_sel_e regfilemux_sel;
    } lc3b_control_word;

    // ----------------------------------------------------------------------
    // instruction word views
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [3:0] opcode;
        lc3b_nzp    nzp;
        logic [8:0] offset9;             // low byte doubles as the trap vector.
    } lc3b_br_view_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] dr;
        logic [2:0] sr;
        logic       a;
        logic       d;
        logic [3:0] imm4;
    } lc3b_shf_view_t;

    typedef union packed {
        lc3b_br_view_t  br;
        lc3b_shf_view_t shf;
    } lc3b_instr_u;

endpackage : lc3b_pkg
